/* design/mipsPkg.sv */
`default_nettype none

package mipsPkg;

	// datapath and register index widths
	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	// word-addressed memories
	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int IMEM_ADDR_W = 6;
	localparam int DMEM_ADDR_W = 6;

	typedef logic [XLEN-1:0] dataT;
	typedef logic [REG_ADDR_W-1:0] regAddrT;

	// supported opcodes
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_SW = 6'b101011;
	localparam logic [5:0] OP_BEQ = 6'b000100;

	// r-type function field
	localparam logic [5:0] FUNCT_ADD = 6'b100000;
	localparam logic [5:0] FUNCT_SUB = 6'b100010;
	localparam logic [5:0] FUNCT_AND = 6'b100100;
	localparam logic [5:0] FUNCT_OR = 6'b100101;
	localparam logic [5:0] FUNCT_SLT = 6'b101010;

	// coarse ALU class set by the decoder, refined by funct in EX
	localparam logic [1:0] ALU_CLASS_ADD = 2'b00;
	localparam logic [1:0] ALU_CLASS_SUB = 2'b01;
	localparam logic [1:0] ALU_CLASS_FUNCT = 2'b10;

	typedef enum logic [3:0] {
		ALU_AND = 4'b0000,
		ALU_OR = 4'b0001,
		ALU_ADD = 4'b0010,
		ALU_SUB = 4'b0110,
		ALU_SLT = 4'b0111
	} aluOpT;

	// operand source for the EX stage
	typedef enum logic [1:0] {
		FWD_REG = 2'b00,
		FWD_WB = 2'b01,
		FWD_EXMEM = 2'b10
	} fwdSelT;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic memRead;
		logic memWrite;
		logic branch;
		logic aluSrc;
		logic regDst;
		logic [1:0] aluClass;
	} ctrlT;

	// all-zero payloads are bubbles
	typedef struct packed {
		ctrlT ctrl;
		dataT pcPlus4;
		dataT rsData;
		dataT rtData;
		dataT imm;
		regAddrT rs;
		regAddrT rt;
		regAddrT rd;
		logic [5:0] funct;
	} idExT;

	typedef struct packed {
		ctrlT ctrl;
		dataT branchTarget;
		logic zero;
		dataT aluResult;
		dataT storeData;
		regAddrT dest;
	} exMemT;

endpackage

`default_nettype wire

/* design/pipeStageReg.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeStageReg #(
	parameter type payloadT = logic
) (
	input wire clk,
	input wire reset,
	input wire clear,
	input wire payloadT d,
	output payloadT q
);

	// clear loads a bubble, every control bit low
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			q <= '0;
		end else if (clear) begin
			q <= '0;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

/* design/fetchStage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage (
	input wire clk,
	input wire reset,
	input wire stall,
	input wire branchTaken,
	input wire mipsPkg::dataT branchTarget,
	input wire progWrite,
	input wire mipsPkg::dataT progAddr,
	input wire mipsPkg::dataT progData,
	output mipsPkg::dataT instr,
	output mipsPkg::dataT pcPlus4
);

	import mipsPkg::*;

	dataT pc;
	dataT pcNext4;
	dataT fetched;
	dataT imem [IMEM_DEPTH];

	assign pcNext4 = pc + 32'd4;
	// word index from the byte PC
	assign fetched = imem[pc[IMEM_ADDR_W+1:2]];

	// program load port, progAddr is a byte address
	always_ff @(posedge clk) begin
		if (progWrite) begin
			imem[progAddr[IMEM_ADDR_W+1:2]] <= progData;
		end
	end

	// taken branch wins over a load-use hold
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (branchTaken) begin
			pc <= branchTarget;
		end else if (!stall) begin
			pc <= pcNext4;
		end
	end

	// IF/ID register
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			instr <= '0;
			pcPlus4 <= '0;
		end else if (branchTaken) begin
			// flush the wrong-path fetch
			instr <= '0;
			pcPlus4 <= '0;
		end else if (!stall) begin
			instr <= fetched;
			pcPlus4 <= pcNext4;
		end
	end

endmodule

`default_nettype wire

/* design/decodeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input wire clk,
	input wire reset,
	input wire mipsPkg::dataT instr,
	input wire mipsPkg::dataT pcPlus4,
	input wire wbValid,
	input wire mipsPkg::regAddrT wbReg,
	input wire mipsPkg::dataT wbData,
	output mipsPkg::idExT idEx
);

	import mipsPkg::*;

	logic [5:0] opcode;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	ctrlT ctrl;
	dataT rsData;
	dataT rtData;
	dataT regs [2**REG_ADDR_W];

	// instruction fields
	assign opcode = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];

	//////////////////////////////////////////////////////////////////////
	// main control
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = '0;
		case (opcode)
			OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.aluClass = ALU_CLASS_FUNCT;
			end
			OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = ALU_CLASS_ADD;
			end
			OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = ALU_CLASS_ADD;
			end
			OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluClass = ALU_CLASS_ADD;
			end
			// compare by subtraction, zero flag decides
			OP_BEQ: begin
				ctrl.branch = 1'b1;
				ctrl.aluClass = ALU_CLASS_SUB;
			end
			// anything else stays a no-op
			default: begin
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// register file
	//////////////////////////////////////////////////////////////////////
	// wbValid is never set for r0, so r0 holds zero
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 2**REG_ADDR_W; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbReg] <= wbData;
		end
	end

	// write-through, same-cycle writeback is visible
	assign rsData = (wbValid && wbReg == rs) ? wbData : regs[rs];
	assign rtData = (wbValid && wbReg == rt) ? wbData : regs[rt];

	// ID/EX payload
	always_comb begin
		idEx.ctrl = ctrl;
		idEx.pcPlus4 = pcPlus4;
		idEx.rsData = rsData;
		idEx.rtData = rtData;
		// sign extension
		idEx.imm = {{(XLEN-16){instr[15]}}, instr[15:0]};
		idEx.rs = rs;
		idEx.rt = rt;
		idEx.rd = rd;
		idEx.funct = instr[5:0];
	end

endmodule

`default_nettype wire

/* design/executeStage.sv */
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input wire mipsPkg::idExT idEx,
	input wire mipsPkg::fwdSelT fwdA,
	input wire mipsPkg::fwdSelT fwdB,
	input wire mipsPkg::dataT memFwdData,
	input wire mipsPkg::dataT wbData,
	output mipsPkg::exMemT exMem
);

	import mipsPkg::*;

	aluOpT aluOp;
	dataT opA;
	dataT rtVal;
	dataT opB;
	dataT result;

	// operand source select
	function automatic dataT pickOperand(fwdSelT sel, dataT regVal, dataT memVal,
		dataT wbVal);
		case (sel)
			FWD_EXMEM: return memVal;
			FWD_WB: return wbVal;
			default: return regVal;
		endcase
	endfunction

	// ALU control from class and funct
	always_comb begin
		case (idEx.ctrl.aluClass)
			ALU_CLASS_SUB: aluOp = ALU_SUB;
			ALU_CLASS_FUNCT: begin
				case (idEx.funct)
					FUNCT_SUB: aluOp = ALU_SUB;
					FUNCT_AND: aluOp = ALU_AND;
					FUNCT_OR: aluOp = ALU_OR;
					FUNCT_SLT: aluOp = ALU_SLT;
					// FUNCT_ADD and unknown functs
					default: aluOp = ALU_ADD;
				endcase
			end
			default: aluOp = ALU_ADD;
		endcase
	end

	assign opA = pickOperand(fwdA, idEx.rsData, memFwdData, wbData);
	// forwarded rt also feeds the store data
	assign rtVal = pickOperand(fwdB, idEx.rtData, memFwdData, wbData);
	assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtVal;

	always_comb begin
		case (aluOp)
			ALU_AND: result = opA & opB;
			ALU_OR: result = opA | opB;
			ALU_SUB: result = opA - opB;
			// signed compare
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: result = opA + opB;
		endcase
	end

	// EX/MEM payload
	always_comb begin
		exMem.ctrl = idEx.ctrl;
		// pcPlus4 plus word offset
		exMem.branchTarget = idEx.pcPlus4 + {idEx.imm[XLEN-3:0], 2'b00};
		exMem.zero = (result == '0);
		exMem.aluResult = result;
		exMem.storeData = rtVal;
		exMem.dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
	end

endmodule

`default_nettype wire

/* design/memoryStage.sv */
`timescale 1ns/10ps
`default_nettype none

module memoryStage (
	input wire clk,
	input wire reset,
	input wire mipsPkg::exMemT exMem,
	output logic branchTaken,
	output mipsPkg::dataT branchTarget,
	output logic storeValid,
	output mipsPkg::dataT storeAddr,
	output mipsPkg::dataT storeData,
	output logic wbValid,
	output mipsPkg::regAddrT wbReg,
	output mipsPkg::dataT wbData
);

	import mipsPkg::*;

	logic [DMEM_ADDR_W-1:0] dmemIndex;
	dataT loadData;
	dataT dmem [DMEM_DEPTH];

	// byte address bits 7..2 pick the word
	assign dmemIndex = exMem.aluResult[DMEM_ADDR_W+1:2];
	assign loadData = dmem[dmemIndex];

	always_ff @(posedge clk) begin
		if (exMem.ctrl.memWrite) begin
			dmem[dmemIndex] <= exMem.storeData;
		end
	end

	// beq resolves here
	assign branchTaken = exMem.ctrl.branch & exMem.zero;
	assign branchTarget = exMem.branchTarget;

	// store trace
	assign storeValid = exMem.ctrl.memWrite;
	assign storeAddr = exMem.aluResult;
	assign storeData = exMem.storeData;

	// MEM/WB register, writes to r0 dropped
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= exMem.ctrl.regWrite && (exMem.dest != '0);
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= exMem.dest;
		wbData <= exMem.ctrl.memToReg ? loadData : exMem.aluResult;
	end

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input wire mipsPkg::regAddrT idExRs,
	input wire mipsPkg::regAddrT idExRt,
	input wire mipsPkg::regAddrT ifIdRs,
	input wire mipsPkg::regAddrT ifIdRt,
	input wire idExMemRead,
	input wire exMemRegWrite,
	input wire mipsPkg::regAddrT exMemRd,
	input wire wbValid,
	input wire mipsPkg::regAddrT wbReg,
	output logic stall,
	output mipsPkg::fwdSelT fwdA,
	output mipsPkg::fwdSelT fwdB
);

	import mipsPkg::*;

	// younger result in EX/MEM wins, r0 never forwarded
	function automatic fwdSelT selectSource(regAddrT src, logic memWr, regAddrT memRd,
		logic wbWr, regAddrT wbRd);
		if (memWr && memRd != '0 && memRd == src) begin
			return FWD_EXMEM;
		end else if (wbWr && wbRd == src) begin
			return FWD_WB;
		end
		return FWD_REG;
	endfunction

	assign fwdA = selectSource(idExRs, exMemRegWrite, exMemRd, wbValid, wbReg);
	assign fwdB = selectSource(idExRt, exMemRegWrite, exMemRd, wbValid, wbReg);

	// load in EX feeding the instruction in ID
	assign stall = idExMemRead && (idExRt != '0) &&
		(idExRt == ifIdRs || idExRt == ifIdRt);

endmodule

`default_nettype wire

/* design/pipeCore.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeCore (
	input wire clk,
	input wire reset,
	input wire progWrite,
	input wire mipsPkg::dataT progAddr,
	input wire mipsPkg::dataT progData,
	output logic storeValid,
	output mipsPkg::dataT storeAddr,
	output mipsPkg::dataT storeData,
	output logic wbValid,
	output mipsPkg::regAddrT wbReg,
	output mipsPkg::dataT wbData
);

	import mipsPkg::*;

	dataT ifIdInstr;
	dataT ifIdPcPlus4;
	logic stall;
	logic branchTaken;
	dataT branchTarget;
	fwdSelT fwdA;
	fwdSelT fwdB;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;

	//////////////////////////////////////////////////////////////////////
	// fetch and decode
	//////////////////////////////////////////////////////////////////////
	fetchStage fetch (
		.clk(clk), .reset(reset), .stall(stall),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.instr(ifIdInstr), .pcPlus4(ifIdPcPlus4)
	);

	decodeStage decode (
		.clk(clk), .reset(reset), .instr(ifIdInstr), .pcPlus4(ifIdPcPlus4),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .idEx(idExD)
	);

	// bubble on load-use stall or taken branch
	pipeStageReg #(.payloadT(idExT)) idExReg (
		.clk(clk), .reset(reset), .clear(stall | branchTaken), .d(idExD), .q(idExQ)
	);

	//////////////////////////////////////////////////////////////////////
	// execute and memory
	//////////////////////////////////////////////////////////////////////
	executeStage execute (
		.idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB),
		.memFwdData(exMemQ.aluResult), .wbData(wbData), .exMem(exMemD)
	);

	pipeStageReg #(.payloadT(exMemT)) exMemReg (
		.clk(clk), .reset(reset), .clear(branchTaken), .d(exMemD), .q(exMemQ)
	);

	memoryStage memory (
		.clk(clk), .reset(reset), .exMem(exMemQ),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	// forwarding and load-use detection
	hazardUnit hazard (
		.idExRs(idExQ.rs), .idExRt(idExQ.rt),
		.ifIdRs(ifIdInstr[25:21]), .ifIdRt(ifIdInstr[20:16]),
		.idExMemRead(idExQ.ctrl.memRead),
		.exMemRegWrite(exMemQ.ctrl.regWrite), .exMemRd(exMemQ.dest),
		.wbValid(wbValid), .wbReg(wbReg),
		.stall(stall), .fwdA(fwdA), .fwdB(fwdB)
	);

endmodule

`default_nettype wire

/* test/pipeCoreSva.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeCoreSva (
	input wire clk,
	input wire reset,
	input wire wbValid,
	input wire mipsPkg::regAddrT wbReg,
	input wire mipsPkg::dataT wbData,
	input wire storeValid,
	input wire mipsPkg::dataT storeAddr
);

	import mipsPkg::*;

	// retired writes never name r0
	wbRegNonZero: assert property (@(posedge clk) disable iff (reset)
		wbValid |-> wbReg != '0)
		else $error("writeback reported for register 0");

	// trace payloads known while reported
	traceKnown: assert property (@(posedge clk) disable iff (reset)
		(wbValid || storeValid) |-> !$isunknown({wbData, storeAddr}))
		else $error("trace payload has unknown bits");

	// nothing retires in the first cycle out of reset
	quietAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> (!wbValid && !storeValid))
		else $error("trace active in the first cycle after reset");

endmodule

bind pipeCore pipeCoreSva coreChecks (
	.clk(clk), .reset(reset), .wbValid(wbValid), .wbReg(wbReg),
	.wbData(wbData), .storeValid(storeValid), .storeAddr(storeAddr)
);

`default_nettype wire

/* test/pipeCoreTb.sv */
`timescale 1ns/10ps
`default_nettype none

module pipeCoreTb;

	import mipsPkg::*;

	localparam int MAX_PROG = 20;
	localparam int DRAIN_CYCLES = 12;
	localparam int MAX_STEPS = 200;
	localparam int NUM_RUNS = 6;
	// load, at most four cycles per instruction, pipeline fill, drain
	localparam int RUN_CYCLES = (MAX_PROG + 4) + 4 * MAX_PROG + 8 + DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES;
	// beq r0, r0, -1 spins in place
	localparam dataT HALT_WORD = {OP_BEQ, 5'd0, 5'd0, 16'hFFFF};

	logic clk;
	logic reset;
	logic progWrite;
	dataT progAddr;
	dataT progData;
	logic storeValid;
	dataT storeAddr;
	dataT storeData;
	logic wbValid;
	regAddrT wbReg;
	dataT wbData;

	dataT prog [$];
	regAddrT expWbReg [$];
	dataT expWbData [$];
	dataT expStAddr [$];
	dataT expStData [$];
	regAddrT obsWbReg [$];
	dataT obsWbData [$];
	dataT obsStAddr [$];
	dataT obsStData [$];
	dataT modelRegs [32];
	dataT modelMem [DMEM_DEPTH];
	logic [31:0] rngState;
	int cycleCount;
	int errorCount;

	pipeCore dut_i (
		.clk(clk), .reset(reset),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.storeValid(storeValid), .storeAddr(storeAddr), .storeData(storeData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
	);

	always #5 clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// failure reporting and timeout
	//////////////////////////////////////////////////////////////////////
	task automatic failNow(string why);
		errorCount++;
		$display("%s", why);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES) begin
			failNow($sformatf("timeout, run still going after %0d cycles", cycleCount));
		end
	end

	task automatic checkWb(regAddrT gotReg, dataT gotData, regAddrT expReg, dataT expData);
		if (gotReg !== expReg) begin
			$display("[FAIL] t=%0t wbReg got %0d expected %0d", $time, gotReg, expReg);
			failNow("writeback register mismatch");
		end else if (gotData !== expData) begin
			$display("[FAIL] t=%0t wbData got %h expected %h", $time, gotData, expData);
			failNow("writeback data mismatch");
		end
	endtask

	task automatic checkStore(dataT gotAddr, dataT gotData, dataT expAddr, dataT expData);
		if (gotAddr !== expAddr) begin
			$display("[FAIL] t=%0t storeAddr got %h expected %h", $time, gotAddr, expAddr);
			failNow("store address mismatch");
		end else if (gotData !== expData) begin
			$display("[FAIL] t=%0t storeData got %h expected %h", $time, gotData, expData);
			failNow("store data mismatch");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// encoders and random immediates
	//////////////////////////////////////////////////////////////////////
	function automatic dataT rType(logic [5:0] funct, regAddrT rd, regAddrT rs, regAddrT rt);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic dataT iType(logic [5:0] op, regAddrT rt, regAddrT rs, logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [15:0] nextImm();
		rngState = xorshift32(rngState);
		return rngState[15:0];
	endfunction

	//////////////////////////////////////////////////////////////////////
	// ISA-level reference model
	//////////////////////////////////////////////////////////////////////
	// r0 writes vanish, as in the trace
	task automatic modelWrite(regAddrT r, dataT v);
		if (r != '0) begin
			modelRegs[r] = v;
			expWbReg.push_back(r);
			expWbData.push_back(v);
		end
	endtask

	task automatic buildExpected();
		dataT pc;
		dataT w;
		dataT imm;
		dataT a;
		dataT b;
		dataT addr;
		logic halted;
		int steps;
		int i;
		expWbReg.delete();
		expWbData.delete();
		expStAddr.delete();
		expStData.delete();
		for (i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		pc = '0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < MAX_STEPS) begin
			steps++;
			i = int'(pc >> 2);
			// past the program is all-zero, a no-op
			w = (i < prog.size()) ? prog[i] : '0;
			imm = {{16{w[15]}}, w[15:0]};
			a = modelRegs[w[25:21]];
			b = modelRegs[w[20:16]];
			addr = a + imm;
			pc = pc + 32'd4;
			if (w == HALT_WORD) begin
				halted = 1'b1;
			end else begin
				case (w[31:26])
					OP_RTYPE: begin
						case (w[5:0])
							FUNCT_ADD: modelWrite(w[15:11], a + b);
							FUNCT_SUB: modelWrite(w[15:11], a - b);
							FUNCT_AND: modelWrite(w[15:11], a & b);
							FUNCT_OR: modelWrite(w[15:11], a | b);
							FUNCT_SLT: modelWrite(w[15:11],
								($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
							default: begin
							end
						endcase
					end
					OP_ADDI: modelWrite(w[20:16], addr);
					OP_LW: modelWrite(w[20:16], modelMem[addr[DMEM_ADDR_W+1:2]]);
					OP_SW: begin
						expStAddr.push_back(addr);
						expStData.push_back(b);
						modelMem[addr[DMEM_ADDR_W+1:2]] = b;
					end
					// offset counts words past pc+4
					OP_BEQ: begin
						if (a == b) begin
							pc = pc + {imm[29:0], 2'b00};
						end
					end
					default: begin
					end
				endcase
			end
		end
		if (!halted) begin
			failNow("reference model never reached the halt loop");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// program load and trace collection
	//////////////////////////////////////////////////////////////////////
	task automatic collectTrace();
		int idle;
		idle = 0;
		obsWbReg.delete();
		obsWbData.delete();
		obsStAddr.delete();
		obsStData.delete();
		while (idle < DRAIN_CYCLES) begin
			@(negedge clk);
			if (wbValid) begin
				obsWbReg.push_back(wbReg);
				obsWbData.push_back(wbData);
				if (expWbReg.size() == 0) begin
					failNow($sformatf("unexpected writeback to r%0d at %0t", wbReg, $time));
				end else begin
					checkWb(wbReg, wbData, expWbReg.pop_front(), expWbData.pop_front());
				end
			end
			if (storeValid) begin
				obsStAddr.push_back(storeAddr);
				obsStData.push_back(storeData);
				if (expStAddr.size() == 0) begin
					failNow($sformatf("unexpected store to %h at %0t", storeAddr, $time));
				end else begin
					checkStore(storeAddr, storeData, expStAddr.pop_front(), expStData.pop_front());
				end
			end
			// halted core must stay quiet through the drain
			if (expWbReg.size() == 0 && expStAddr.size() == 0) begin
				idle++;
			end
		end
	endtask

	task automatic loadAndRun();
		int count;
		int i;
		buildExpected();
		count = (prog.size() + 4 < 10) ? 10 : prog.size() + 4;
		@(negedge clk);
		reset = 1'b1;
		// program plus a zero tail for the halt shadow
		for (i = 0; i < count; i++) begin
			progWrite = 1'b1;
			progAddr = i * 4;
			progData = (i < prog.size()) ? prog[i] : '0;
			@(negedge clk);
			if (wbValid || storeValid) begin
				failNow("trace output active while reset is held");
			end
		end
		progWrite = 1'b0;
		reset = 1'b0;
		collectTrace();
	endtask

	//////////////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////////////
	task automatic testAluChain();
		prog.delete();
		prog.push_back(iType(OP_ADDI, 5'd1, 5'd0, nextImm()));
		prog.push_back(iType(OP_ADDI, 5'd2, 5'd0, nextImm()));
		// r3 forced negative for slt
		prog.push_back(iType(OP_ADDI, 5'd3, 5'd0, nextImm() | 16'h8000));
		prog.push_back(rType(FUNCT_ADD, 5'd4, 5'd1, 5'd2));
		prog.push_back(rType(FUNCT_SUB, 5'd5, 5'd4, 5'd3));
		prog.push_back(rType(FUNCT_AND, 5'd6, 5'd5, 5'd4));
		prog.push_back(rType(FUNCT_OR, 5'd7, 5'd6, 5'd5));
		prog.push_back(rType(FUNCT_SLT, 5'd8, 5'd3, 5'd7));
		prog.push_back(rType(FUNCT_SLT, 5'd9, 5'd7, 5'd3));
		prog.push_back(rType(FUNCT_SLT, 5'd10, 5'd3, 5'd1));
		prog.push_back(HALT_WORD);
		loadAndRun();
	endtask

	task automatic buildStoreLoadProgram();
		prog.delete();
		prog.push_back(iType(OP_ADDI, 5'd1, 5'd0, 16'd16));
		prog.push_back(iType(OP_ADDI, 5'd2, 5'd0, 16'h0123));
		prog.push_back(iType(OP_SW, 5'd2, 5'd1, 16'd8));
		prog.push_back(iType(OP_LW, 5'd3, 5'd1, 16'd8));
		// load-use stall on r3
		prog.push_back(rType(FUNCT_ADD, 5'd4, 5'd3, 5'd2));
		prog.push_back(iType(OP_SW, 5'd4, 5'd1, 16'd12));
		prog.push_back(iType(OP_LW, 5'd5, 5'd1, 16'd12));
		// stall on store data, negative offset
		prog.push_back(iType(OP_SW, 5'd5, 5'd1, 16'hFFF8));
		prog.push_back(HALT_WORD);
	endtask

	task automatic testStoreLoad();
		buildStoreLoadProgram();
		loadAndRun();
	endtask

	task automatic testTakenBranch();
		prog.delete();
		prog.push_back(iType(OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(iType(OP_ADDI, 5'd2, 5'd0, 16'd5));
		prog.push_back(iType(OP_BEQ, 5'd2, 5'd1, 16'd3));
		// shadow, all three flushed
		prog.push_back(iType(OP_ADDI, 5'd3, 5'd0, 16'd1));
		prog.push_back(iType(OP_ADDI, 5'd4, 5'd0, 16'd2));
		prog.push_back(iType(OP_SW, 5'd1, 5'd0, 16'd0));
		prog.push_back(iType(OP_ADDI, 5'd6, 5'd0, 16'd7));
		prog.push_back(rType(FUNCT_ADD, 5'd7, 5'd6, 5'd1));
		prog.push_back(HALT_WORD);
		loadAndRun();
	endtask

	task automatic testNotTakenBranch();
		prog.delete();
		prog.push_back(iType(OP_ADDI, 5'd1, 5'd0, 16'd5));
		prog.push_back(iType(OP_ADDI, 5'd2, 5'd0, 16'd6));
		prog.push_back(iType(OP_BEQ, 5'd2, 5'd1, 16'd2));
		prog.push_back(iType(OP_ADDI, 5'd3, 5'd0, 16'd1));
		prog.push_back(rType(FUNCT_ADD, 5'd4, 5'd1, 5'd2));
		prog.push_back(iType(OP_SW, 5'd4, 5'd0, 16'd4));
		prog.push_back(HALT_WORD);
		loadAndRun();
	endtask

	// second reset and rerun must repeat the trace exactly
	task automatic testResetRerun();
		regAddrT firstReg [$];
		dataT firstData [$];
		dataT firstStAddr [$];
		dataT firstStData [$];
		int i;
		buildStoreLoadProgram();
		// reads r4 and r5 left over from the run before, zero only after reset
		prog.push_front(rType(FUNCT_ADD, 5'd6, 5'd4, 5'd5));
		loadAndRun();
		firstReg = obsWbReg;
		firstData = obsWbData;
		firstStAddr = obsStAddr;
		firstStData = obsStData;
		loadAndRun();
		if (obsWbReg.size() != firstReg.size() || obsStAddr.size() != firstStAddr.size()) begin
			failNow("rerun after reset gave a different number of trace events");
		end else begin
			for (i = 0; i < firstReg.size(); i++) begin
				checkWb(obsWbReg[i], obsWbData[i], firstReg[i], firstData[i]);
			end
			for (i = 0; i < firstStAddr.size(); i++) begin
				checkStore(obsStAddr[i], obsStData[i], firstStAddr[i], firstStData[i]);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		rngState = 32'ha031;
		cycleCount = 0;
		errorCount = 0;
		testAluChain();
		testStoreLoad();
		testTakenBranch();
		testNotTakenBranch();
		testResetRerun();
		if (errorCount == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			failNow("errors were counted during the run");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
design/mipsPkg.sv
design/pipeStageReg.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/pipeCore.sv
test/pipeCoreSva.sv
test/pipeCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# build the pipeline testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module pipeCoreTb -f sources.f -o pipeCoreSim \
	&& obj_dir/pipeCoreSim | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }
